// ==== hw/spi_pkg.sv ====
// Shared sizes and types of the SPI master.
package spi_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Number of bits shifted in one SPI frame.
    localparam int WORD_BITS = 8;

    // Width of the half period counter in the sck divider.
    // The longest half period is 256 clock cycles.
    localparam int DIV_BITS = 9;

    ////////////////////
    // Types
    ////////////////////

    // One data word as seen on mosi and miso.
    typedef logic [WORD_BITS-1:0] word_t;

    // SPI mode. Bit 1 is the clock polarity and so the idle level of sck.
    // Bit 0 is the clock phase. With phase 0 the first edge samples.
    typedef logic [1:0] spi_mode_t;

    // Prescale exponent. The sck half period is 2**(prescale+1) clock cycles.
    typedef logic [2:0] prescale_t;

    // A word together with the settings it must be sent with.
    // The settings travel with the word so that a later change of the
    // inputs never disturbs a frame that is already shifting.
    typedef struct packed {
        word_t     data;       // Word to put on mosi.
        spi_mode_t mode;       // Polarity and phase for this frame.
        logic      lsb_first;  // Set for LSB first, clear for MSB first.
        prescale_t prescale;   // Divider exponent for this frame.
    } tx_item_t;

endpackage

// ==== hw/hold_slot.sv ====
`timescale 1ns/1ns

// One-entry holding register with a full flag.
// A word offered while the slot is full is thrown away and the sticky
// overflow flag records the loss until err_clr is pulsed.
module hold_slot #(
    parameter type payload_t = logic  // Payload carried by the slot.
) (
    input  logic     wr,        // Clock.
    input  logic     rst,       // Asynchronous reset, active high.
    input  logic     put,       // One-cycle strobe that offers item.
    input  payload_t item,      // Payload offered with put.
    input  logic     take,      // One-cycle strobe that empties the slot.
    input  logic     err_clr,   // Clears the overflow flag.
    output logic     full,      // The slot holds a payload.
    output payload_t held,      // The stored payload.
    output logic     overflow   // Sticky flag for a rejected put.
);

    logic store;  // The offered item is accepted this cycle.

    // Only an empty slot accepts a new item.
    assign store = put && !full;

    ////////////////////
    // Flags
    ////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            full     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            // A take only matters while something is held.
            if (full && take) begin
                full <= 1'b0;
            end else if (store) begin
                full <= 1'b1;  // Visible from the next cycle.
            end

            // Clearing wins over a rejection in the same cycle.
            if (err_clr) begin
                overflow <= 1'b0;
            end else if (put && full) begin
                overflow <= 1'b1;  // The item is dropped and the loss remembered.
            end
        end
    end

    // Payload register, written only when a put is accepted.
    always_ff @(posedge wr) begin
        if (store) begin
            held <= item;
        end
    end

endmodule

// ==== hw/sck_divider.sv ====
`timescale 1ns/1ns

// Half period tick generator for sck.
// While run is high it pulses half_tick once every 2**(prescale+1) cycles.
// The count restarts from zero whenever run is low.
module sck_divider #(
    parameter int DIV_BITS = 9  // Counter width.
) (
    input  logic              wr,        // Clock.
    input  logic              rst,       // Asynchronous reset, active high.
    input  logic              run,       // High for the whole frame.
    input  spi_pkg::prescale_t prescale, // Exponent captured with the frame.
    output logic              half_tick  // One-cycle pulse per half period.
);

    localparam logic [DIV_BITS-1:0] ONE = 1;  // Unit step of the counter.

    logic [DIV_BITS-1:0] cnt;        // Cycles counted in this half period.
    logic [DIV_BITS-1:0] term;       // Last count value of a half period.
    logic [3:0]          shift_amt;  // prescale + 1 without wrap at 7.

    // The half period is 2**(prescale+1) cycles, so the count runs from 0 up
    // to 2**(prescale+1)-1. Widen before adding so an exponent of 7 gives 8.
    assign shift_amt = {1'b0, prescale} + 4'd1;
    assign term      = (ONE << shift_amt) - ONE;

    // The tick is raised in the last cycle of each half period.
    assign half_tick = run && (cnt == term);

    ////////////////////
    // Counter
    ////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;  // Held at zero between frames.
        end else if (cnt == term) begin
            cnt <= '0;  // Wrap so the next half period starts at once.
        end else begin
            cnt <= cnt + ONE;
        end
    end

endmodule

// ==== hw/spi_engine.sv ====
`timescale 1ns/1ns

// SPI frame sequencer.
// It loads a word and its settings from the transmit slot, runs the
// divider for the whole frame, drives ss, sck and mosi, samples miso and
// hands the received word to the receive slot at the end of the frame.
module spi_engine #(
    parameter int DIV_BITS = 9  // Width of the divider counter.
) (
    input  logic              wr,       // Clock.
    input  logic              rst,      // Asynchronous reset, active high.
    input  logic              tx_full,  // The transmit slot holds an item.
    input  spi_pkg::tx_item_t tx_item,  // Item waiting in the transmit slot.
    input  logic              miso,     // Serial data from the slave.
    output logic              tx_take,  // Loads tx_item this cycle.
    output logic              rx_put,   // A received word is ready this cycle.
    output spi_pkg::word_t    rx_word,  // Word received in the last frame.
    output logic              sck,      // SPI clock.
    output logic              mosi,     // Serial data to the slave.
    output logic              ss        // Slave select, active low.
);

    localparam int W       = spi_pkg::WORD_BITS;
    localparam int EDGES   = 2 * W;                // sck edges per frame.
    localparam int EC_BITS = $clog2(EDGES) + 1;    // Holds 0 up to EDGES.
    localparam logic [EC_BITS-1:0] LAST_EDGE = EC_BITS'(EDGES);

    ////////////////////
    // Declarations
    ////////////////////

    logic                busy_q;     // A frame is in progress.
    logic                ss_q;       // Registered slave select.
    logic                mosi_q;     // Bit currently driven on mosi.
    logic [EC_BITS-1:0]  edge_cnt;   // sck edges issued in this frame.
    spi_pkg::spi_mode_t  mode_q;     // Mode of the current or last frame.
    logic                lsb_q;      // Bit order of the current frame.
    spi_pkg::prescale_t  presc_q;    // Prescale of the current frame.
    spi_pkg::word_t      shift_out;  // Bits still to be sent.
    spi_pkg::word_t      shift_in;   // Bits collected from miso.
    logic                half_tick;  // One half period has passed.
    logic                last_tick;  // Half period after the last edge.
    logic                step;       // Issue the next sck edge now.
    logic                sample_edge; // The next edge samples miso.

    // Bit that leaves the word first for the given order.
    function automatic logic lead_bit(spi_pkg::word_t w, logic lsb);
        return lsb ? w[0] : w[W-1];
    endfunction

    // Word with its leading bit removed. Ones fill in behind it.
    function automatic spi_pkg::word_t drop_lead(spi_pkg::word_t w, logic lsb);
        if (lsb) begin
            return {1'b1, w[W-1:1]};
        end
        return {w[W-2:0], 1'b1};
    endfunction

    ////////////////////
    // Half period timing
    ////////////////////

    // The divider runs exactly while a frame is busy. Back-to-back frames
    // keep it running, and the count has just wrapped when the next starts.
    sck_divider #(
        .DIV_BITS (DIV_BITS)
    ) u_sck_divider (
        .wr        (wr),
        .rst       (rst),
        .run       (busy_q),
        .prescale  (presc_q),
        .half_tick (half_tick)
    );

    // After all edges one more half period closes the frame.
    assign last_tick = busy_q && half_tick && (edge_cnt == LAST_EDGE);
    assign step      = busy_q && half_tick && (edge_cnt != LAST_EDGE);

    // A new item is loaded when idle, or right at the end of a frame so that
    // ss stays low between the two words.
    assign tx_take = tx_full && (!busy_q || last_tick);
    assign rx_put  = last_tick;
    assign rx_word = shift_in;

    // Edges are numbered from one. With phase 0 the odd edges sample and with
    // phase 1 the even ones do. edge_cnt is the number of edges already issued.
    assign sample_edge = (edge_cnt[0] == mode_q[0]);

    // sck toggles with every edge and rests at the polarity of the last mode.
    assign sck  = edge_cnt[0] ^ mode_q[1];
    assign mosi = ss_q ? 1'b1 : mosi_q;  // Idle high outside a frame.
    assign ss   = ss_q;

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            busy_q   <= 1'b0;
            ss_q     <= 1'b1;
            mosi_q   <= 1'b1;
            edge_cnt <= '0;
            mode_q   <= '0;  // sck rests low after reset.
            lsb_q    <= 1'b0;
            presc_q  <= '0;
        end else if (tx_take) begin
            // Start of a frame. The settings are frozen for its length.
            busy_q   <= 1'b1;
            ss_q     <= 1'b0;
            edge_cnt <= '0;
            mode_q   <= tx_item.mode;
            lsb_q    <= tx_item.lsb_first;
            presc_q  <= tx_item.prescale;
            // Phase 0 needs the first bit before the first edge.
            if (tx_item.mode[0]) begin
                mosi_q <= 1'b1;
            end else begin
                mosi_q <= lead_bit(tx_item.data, tx_item.lsb_first);
            end
        end else if (last_tick) begin
            // End of the frame with nothing queued behind it.
            busy_q   <= 1'b0;
            ss_q     <= 1'b1;
            edge_cnt <= '0;
            mosi_q   <= 1'b1;
        end else if (step) begin
            edge_cnt <= edge_cnt + 1'b1;
            if (!sample_edge) begin
                mosi_q <= lead_bit(shift_out, lsb_q);  // Next bit on the change edge.
            end
        end
    end

    // Shift registers for the bits going out and the bits coming in.
    always_ff @(posedge wr) begin
        if (tx_take) begin
            // In phase 0 the first bit is already on mosi, so drop it here.
            if (tx_item.mode[0]) begin
                shift_out <= tx_item.data;
            end else begin
                shift_out <= drop_lead(tx_item.data, tx_item.lsb_first);
            end
        end else if (step) begin
            if (sample_edge) begin
                // The first bit in ends up at the end it left from.
                if (lsb_q) begin
                    shift_in <= {miso, shift_in[W-1:1]};
                end else begin
                    shift_in <= {shift_in[W-2:0], miso};
                end
            end else begin
                shift_out <= drop_lead(shift_out, lsb_q);
            end
        end
    end

endmodule

// ==== hw/spi_master.sv ====
`timescale 1ns/1ns

// SPI master with a one-word transmit buffer and a one-word receive buffer.
// All inputs are sampled on wr. A send while the transmit buffer is full is
// dropped and flagged in send_err. A received word that finds the receive
// buffer still full is dropped and flagged in rx_lost.
module spi_master (
    input  logic               wr,            // Clock.
    input  logic               rst,           // Asynchronous reset, active high.
    input  logic               send,          // One-cycle request to send data_in.
    input  spi_pkg::word_t     data_in,       // Word to send.
    input  spi_pkg::spi_mode_t mode,          // SPI mode for this word.
    input  logic               lsb_first,     // Bit order for this word.
    input  spi_pkg::prescale_t prescale,      // sck prescale for this word.
    input  logic               rd,            // One-cycle read of data_out.
    input  logic               err_clr,       // Clears send_err and rx_lost.
    input  logic               miso,          // Serial data from the slave.
    output spi_pkg::word_t     data_out,      // Last received word.
    output logic               buff_empty,    // The transmit buffer is free.
    output logic               char_received, // data_out holds an unread word.
    output logic               send_err,      // A send was dropped.
    output logic               rx_lost,       // A received word was dropped.
    output logic               sck,           // SPI clock.
    output logic               mosi,          // Serial data to the slave.
    output logic               ss             // Slave select, active low.
);

    ////////////////////
    // Internal nets
    ////////////////////

    spi_pkg::tx_item_t tx_in;    // Word and settings offered by send.
    spi_pkg::tx_item_t tx_item;  // Item waiting for the engine.
    logic              tx_full;  // The transmit slot is occupied.
    logic              tx_take;  // The engine loads the waiting item.
    logic              rx_put;   // The engine has finished a word.
    spi_pkg::word_t    rx_word;  // Word finished by the engine.

    // The settings are bundled with the word at the moment of the send.
    assign tx_in.data      = data_in;
    assign tx_in.mode      = mode;
    assign tx_in.lsb_first = lsb_first;
    assign tx_in.prescale  = prescale;

    assign buff_empty = ~tx_full;

    ////////////////////
    // Transmit side
    ////////////////////

    hold_slot #(
        .payload_t (spi_pkg::tx_item_t)
    ) u_tx_slot (
        .wr       (wr),
        .rst      (rst),
        .put      (send),
        .item     (tx_in),
        .take     (tx_take),   // Emptied when the engine loads the item.
        .err_clr  (err_clr),
        .full     (tx_full),
        .held     (tx_item),
        .overflow (send_err)
    );

    ////////////////////
    // Frame engine
    ////////////////////

    spi_engine #(
        .DIV_BITS (spi_pkg::DIV_BITS)
    ) u_spi_engine (
        .wr      (wr),
        .rst     (rst),
        .tx_full (tx_full),
        .tx_item (tx_item),
        .miso    (miso),
        .tx_take (tx_take),
        .rx_put  (rx_put),
        .rx_word (rx_word),
        .sck     (sck),
        .mosi    (mosi),
        .ss      (ss)
    );

    ////////////////////
    // Receive side
    ////////////////////

    // Same slot as on the transmit side. Its full flag is char_received.
    hold_slot #(
        .payload_t (spi_pkg::word_t)
    ) u_rx_slot (
        .wr       (wr),
        .rst      (rst),
        .put      (rx_put),
        .item     (rx_word),
        .take     (rd),        // Reading frees the slot for the next word.
        .err_clr  (err_clr),
        .full     (char_received),
        .held     (data_out),
        .overflow (rx_lost)
    );

endmodule

// ==== verif/spi_master_tb.sv ====
`timescale 1ns/1ns

module spi_master_tb;

    localparam logic [31:0] SEED          = 32'h8d2b_4693;
    localparam int          N_FRAMES      = 24;    // Random frames before the directed ones.
    localparam int          DEPTH         = 64;    // Room for every word of the run.
    localparam int          EMPTY_TIMEOUT = 20;    // Cycles to wait for buff_empty.
    localparam int          FRAME_TIMEOUT = 6000;  // Longest frame is 17 half periods of 256.
    localparam int          EDGES         = 2 * spi_pkg::WORD_BITS;

    logic               wr = 1'b0;
    logic               rst;
    logic               send;
    spi_pkg::word_t     data_in;
    spi_pkg::spi_mode_t mode;
    logic               lsb_first;
    spi_pkg::prescale_t prescale;
    logic               rd;
    logic               err_clr;
    logic               miso = 1'b1;  // Driven by the slave model only.
    spi_pkg::word_t     data_out;
    logic               buff_empty;
    logic               char_received;
    logic               send_err;
    logic               rx_lost;
    logic               sck;
    logic               mosi;
    logic               ss;

    // Words the DUT accepted, with the reply the slave gives to each.
    spi_pkg::tx_item_t  sent_items [DEPTH];
    spi_pkg::word_t     sent_replies [DEPTH];
    int                 sent_count = 0;
    spi_pkg::word_t     got_replies [DEPTH];  // Replies of finished frames, in order.
    int                 got_count = 0;
    int                 read_count = 0;       // Replies already compared with data_out.
    logic [31:0]        lfsr_state;

    // State of the SPI slave model.
    logic               frame_active = 1'b0;
    int                 taken_count = 0;      // Frames the slave has started.
    int                 edge_no;              // sck edges seen in this frame.
    int                 cyc_since;            // Cycles since the frame start or last edge.
    int                 half_cycles;          // Expected sck half period.
    logic               prev_sck;
    logic               prev_empty;
    spi_pkg::spi_mode_t last_mode;            // Mode of the last frame, 0 after reset.
    spi_pkg::tx_item_t  cur_item;
    spi_pkg::word_t     cur_reply;
    spi_pkg::word_t     captured;             // Bits the slave took from mosi.

    spi_master i_spi_master (
        .wr            (wr),
        .rst           (rst),
        .send          (send),
        .data_in       (data_in),
        .mode          (mode),
        .lsb_first     (lsb_first),
        .prescale      (prescale),
        .rd            (rd),
        .err_clr       (err_clr),
        .miso          (miso),
        .data_out      (data_out),
        .buff_empty    (buff_empty),
        .char_received (char_received),
        .send_err      (send_err),
        .rx_lost       (rx_lost),
        .sck           (sck),
        .mosi          (mosi),
        .ss            (ss)
    );

    initial begin
        forever begin
            #50 wr = ~wr;  // 100 ns period.
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step for every bit taken.
    task automatic draw_bits(input int count, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Position in the word of the k-th bit on the wire.
    function automatic int bit_pos(input logic lsb, input int k);
        return lsb ? k : spi_pkg::WORD_BITS - 1 - k;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input spi_pkg::word_t exp,
                              input spi_pkg::word_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // The resting level of sck is the polarity bit of the mode.
    task automatic check_mode_pin(input string name, input spi_pkg::spi_mode_t m,
                                  input logic act);
        if (act !== m[1]) begin
            fail_now($sformatf("ERR %s expected %b actual %b", name, m[1], act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_now($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    ////////////////////
    // SPI slave model
    ////////////////////

    // buff_empty rises exactly when the engine loads a word, so it marks a frame start.
    task automatic start_frame();
        if (frame_active) begin
            fail_now("A new frame started before the previous one had all its sck edges");
        end
        if (taken_count >= sent_count) begin
            fail_now("A frame started although no accepted word was waiting");
        end
        cur_item  = sent_items[taken_count];
        cur_reply = sent_replies[taken_count];
        taken_count++;
        check_bit("ss at frame start", 1'b0, ss);
        check_mode_pin("sck at frame start", cur_item.mode, sck);
        frame_active = 1'b1;
        edge_no      = 0;
        cyc_since    = 0;
        half_cycles  = 2 << cur_item.prescale;
        prev_sck     = sck;  // A change of polarity here is no edge.
        last_mode    = cur_item.mode;
        captured     = '0;
        if (!cur_item.mode[0]) begin
            miso = cur_reply[bit_pos(cur_item.lsb_first, 0)];  // Phase 0 needs bit 0 early.
        end
    endtask

    task automatic track_frame();
        check_bit("ss during frame", 1'b0, ss);
        cyc_since++;
        if (sck !== prev_sck) begin
            edge_no++;
            prev_sck = sck;
            check_count("sck half period", half_cycles, cyc_since);
            cyc_since = 0;
            if (edge_no[0] != cur_item.mode[0]) begin
                // Sampling edge. Odd edges for phase 0, even edges for phase 1.
                captured[bit_pos(cur_item.lsb_first, (edge_no - 1) / 2)] = mosi;
            end else if (edge_no / 2 < spi_pkg::WORD_BITS) begin
                miso = cur_reply[bit_pos(cur_item.lsb_first, edge_no / 2)];
            end
            if (edge_no == EDGES) begin
                check_word("word seen by the slave", cur_item.data, captured);
                got_replies[got_count] = cur_reply;
                got_count++;
                frame_active = 1'b0;
            end
        end else if (cyc_since > half_cycles) begin
            fail_now("sck stopped before the frame had all its edges");
        end
    endtask

    // Outputs are stable at the falling edge, and miso changes there too.
    always @(negedge wr) begin
        if (rst) begin
            frame_active = 1'b0;
            last_mode    = '0;
            prev_sck     = 1'b0;
            prev_empty   = 1'b1;
            miso         = 1'b1;
        end else begin
            if (buff_empty && !prev_empty) begin
                start_frame();
            end else if (frame_active) begin
                track_frame();
            end else if (ss) begin
                check_mode_pin("sck while ss high", last_mode, sck);
                check_bit("mosi while ss high", 1'b1, mosi);
            end else if (sck !== prev_sck) begin
                fail_now("An sck edge appeared outside the edges of a frame");
            end
            prev_empty = buff_empty;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic random_item(output spi_pkg::tx_item_t item, output spi_pkg::word_t reply);
        logic [31:0] v;
        draw_bits(spi_pkg::WORD_BITS, v);
        item.data = spi_pkg::word_t'(v);
        draw_bits(2, v);
        item.mode = spi_pkg::spi_mode_t'(v);
        draw_bits(1, v);
        item.lsb_first = v[0];
        draw_bits(3, v);
        item.prescale = spi_pkg::prescale_t'(v);
        draw_bits(spi_pkg::WORD_BITS, v);
        reply = spi_pkg::word_t'(v);  // What the slave answers in this frame.
    endtask

    // A send that the DUT is expected to drop is not recorded.
    task automatic send_item(input spi_pkg::tx_item_t item, input spi_pkg::word_t reply,
                             input bit accepted);
        send      = 1'b1;
        data_in   = item.data;
        mode      = item.mode;
        lsb_first = item.lsb_first;
        prescale  = item.prescale;
        if (accepted) begin
            sent_items[sent_count]   = item;
            sent_replies[sent_count] = reply;
            sent_count++;
        end
        @(negedge wr);
        send = 1'b0;
    endtask

    task automatic wait_empty();
        int n;
        n = 0;
        while (buff_empty !== 1'b1) begin
            @(negedge wr);
            n++;
            if (n > EMPTY_TIMEOUT) begin
                fail_now("Timed out waiting for the transmit buffer to become empty");
            end
        end
    endtask

    // With hold_low set, ss must stay low until the word arrives and also in
    // that cycle, because the queued frame follows at once.
    task automatic wait_received(input bit hold_low);
        int n;
        n = 0;
        while (char_received !== 1'b1) begin
            if (hold_low) begin
                check_bit("ss between back-to-back frames", 1'b0, ss);
            end
            @(negedge wr);
            n++;
            if (n > FRAME_TIMEOUT) begin
                fail_now("Timed out waiting for char_received");
            end
        end
        if (hold_low) begin
            check_bit("ss between back-to-back frames", 1'b0, ss);
        end
    endtask

    task automatic wait_lost();
        int n;
        n = 0;
        while (rx_lost !== 1'b1) begin
            check_bit("char_received before overrun", 1'b1, char_received);
            @(negedge wr);
            n++;
            if (n > FRAME_TIMEOUT) begin
                fail_now("Timed out waiting for rx_lost after an unread word");
            end
        end
    endtask

    task automatic read_check(input string name);
        spi_pkg::word_t exp;
        if (read_count >= got_count) begin
            fail_now("char_received rose although the slave finished no frame");
        end
        exp = got_replies[read_count];
        read_count++;
        check_word(name, exp, data_out);
        rd = 1'b1;
        @(negedge wr);
        rd = 1'b0;
        check_bit("char_received after rd", 1'b0, char_received);
    endtask

    task automatic pulse_err_clr();
        err_clr = 1'b1;
        @(negedge wr);
        err_clr = 1'b0;
    endtask

    initial begin
        spi_pkg::tx_item_t item_a;
        spi_pkg::tx_item_t item_b;
        spi_pkg::tx_item_t item_c;
        spi_pkg::word_t    reply_a;
        spi_pkg::word_t    reply_b;
        spi_pkg::word_t    reply_c;

        rst        = 1'b1;
        send       = 1'b0;
        data_in    = '0;
        mode       = '0;
        lsb_first  = 1'b0;
        prescale   = '0;
        rd         = 1'b0;
        err_clr    = 1'b0;
        lfsr_state = SEED;
        repeat (8) begin
            @(negedge wr);
        end
        rst = 1'b0;
        @(negedge wr);

        check_bit("ss after reset", 1'b1, ss);
        check_bit("mosi after reset", 1'b1, mosi);
        check_mode_pin("sck after reset", '0, sck);
        check_bit("buff_empty after reset", 1'b1, buff_empty);
        check_bit("char_received after reset", 1'b0, char_received);
        check_bit("send_err after reset", 1'b0, send_err);
        check_bit("rx_lost after reset", 1'b0, rx_lost);

        // Single frames with random settings. The slave checks mosi and timing.
        for (int i = 0; i < N_FRAMES; i++) begin
            random_item(item_a, reply_a);
            wait_empty();
            send_item(item_a, reply_a, 1'b1);
            wait_received(1'b0);
            read_check("random frame data_out");
        end

        // Two queued words run back to back, and a third send is dropped.
        random_item(item_a, reply_a);
        random_item(item_b, reply_b);
        random_item(item_c, reply_c);
        wait_empty();
        send_item(item_a, reply_a, 1'b1);
        wait_empty();                       // The first word is now shifting.
        send_item(item_b, reply_b, 1'b1);
        check_bit("buff_empty with a word waiting", 1'b0, buff_empty);
        send_item(item_c, reply_c, 1'b0);
        check_bit("send_err after send into full buffer", 1'b1, send_err);
        pulse_err_clr();
        check_bit("send_err after err_clr", 1'b0, send_err);
        wait_received(1'b1);
        read_check("back-to-back first word");
        wait_received(1'b0);
        read_check("back-to-back second word");

        // A second word that finds the first one unread is lost.
        random_item(item_a, reply_a);
        random_item(item_b, reply_b);
        wait_empty();
        send_item(item_a, reply_a, 1'b1);
        wait_empty();
        send_item(item_b, reply_b, 1'b1);
        wait_received(1'b1);
        wait_lost();
        check_bit("ss after the lost frame", 1'b1, ss);
        read_check("data_out kept after overrun");
        read_count++;                       // The second reply never reaches data_out.
        pulse_err_clr();
        check_bit("rx_lost after err_clr", 1'b0, rx_lost);

        if (taken_count != sent_count) begin
            fail_now("Not every accepted word was sent to the slave");
        end else if (read_count != got_count) begin
            fail_now("Finished frames and read words do not match in number");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
hw/spi_pkg.sv
hw/hold_slot.sv
hw/sck_divider.sv
hw/spi_engine.sv
hw/spi_master.sv
verif/spi_master_tb.sv

// ==== Makefile ====
TOP = spi_master_tb

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only -Wall --top-module spi_master hw/spi_pkg.sv hw/hold_slot.sv \
		hw/sck_divider.sv hw/spi_engine.sv hw/spi_master.sv

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
